/* compile.f */
+incdir+source
source/biu_icb_pkg.sv
source/biu_route_pkg.sv
source/biu_ctrl.sv
source/biu_cmd_dispatch.sv
source/biu_rsp_merge.sv
source/biu_top.sv
verification/biu_ctrl_props.sv
verification/biu_checker.sv
verification/tb_biu.sv

/* source/biu_cmd_dispatch.sv */
/*
  Decodes the command region and fans the ICB command out to one target.
  Payload goes to every target, only the chosen valid is raised.
  A command to a disabled region is accepted here and answered with an error.
*/
`timescale 1ns/1ns
`include "biu_params.svh"

module biu_cmd_dispatch (
  input  logic                     i_cmd_valid,
  output logic                     o_cmd_ready,
  input  biu_icb_pkg::icb_cmd_t    i_cmd,
  input  logic                     i_ppi_enable,
  input  logic                     i_clint_enable,
  input  logic                     i_plic_enable,
  input  logic                     i_mem_enable,
  input  logic                     i_cmd_allow,
  output logic                     o_cmd_fire,
  output biu_route_pkg::biu_tgt_e  o_cmd_tgt,
  output logic                     o_ppi_cmd_valid,
  input  logic                     i_ppi_cmd_ready,
  output biu_icb_pkg::icb_cmd_t    o_ppi_cmd,
  output logic                     o_clint_cmd_valid,
  input  logic                     i_clint_cmd_ready,
  output biu_icb_pkg::icb_cmd_t    o_clint_cmd,
  output logic                     o_plic_cmd_valid,
  input  logic                     i_plic_cmd_ready,
  output biu_icb_pkg::icb_cmd_t    o_plic_cmd,
  output logic                     o_mem_cmd_valid,
  input  logic                     i_mem_cmd_ready,
  output biu_icb_pkg::icb_cmd_t    o_mem_cmd
);

  localparam int REGION_W = `BIU_REGION_HI - `BIU_REGION_LO + 1;

  logic [REGION_W-1:0]     region;
  biu_route_pkg::biu_tgt_e tgt;
  logic                    tgt_ready;
  logic                    issue;

  assign region = i_cmd.addr[`BIU_REGION_HI:`BIU_REGION_LO];

  // Region decode, enables checked per target
  always_comb begin
    if (region == REGION_W'(`BIU_PPI_REGION)) begin
      tgt = i_ppi_enable ? biu_route_pkg::TGT_PPI : biu_route_pkg::TGT_ERR;
    end else if (region == REGION_W'(`BIU_CLINT_REGION)) begin
      tgt = i_clint_enable ? biu_route_pkg::TGT_CLINT : biu_route_pkg::TGT_ERR;
    end else if (region == REGION_W'(`BIU_PLIC_REGION)) begin
      tgt = i_plic_enable ? biu_route_pkg::TGT_PLIC : biu_route_pkg::TGT_ERR;
    end else begin
      tgt = i_mem_enable ? biu_route_pkg::TGT_MEM : biu_route_pkg::TGT_ERR;
    end
  end

  always_comb begin
    case (tgt)
      biu_route_pkg::TGT_PPI:   tgt_ready = i_ppi_cmd_ready;
      biu_route_pkg::TGT_CLINT: tgt_ready = i_clint_cmd_ready;
      biu_route_pkg::TGT_PLIC:  tgt_ready = i_plic_cmd_ready;
      biu_route_pkg::TGT_MEM:   tgt_ready = i_mem_cmd_ready;
      default:                  tgt_ready = 1'b1; // Local error sink
    endcase
  end

  assign issue = i_cmd_valid & i_cmd_allow;

  assign o_ppi_cmd_valid   = issue & (tgt == biu_route_pkg::TGT_PPI);
  assign o_clint_cmd_valid = issue & (tgt == biu_route_pkg::TGT_CLINT);
  assign o_plic_cmd_valid  = issue & (tgt == biu_route_pkg::TGT_PLIC);
  assign o_mem_cmd_valid   = issue & (tgt == biu_route_pkg::TGT_MEM);

  assign o_ppi_cmd   = i_cmd;
  assign o_clint_cmd = i_cmd;
  assign o_plic_cmd  = i_cmd;
  assign o_mem_cmd   = i_cmd;

  assign o_cmd_ready = i_cmd_allow & tgt_ready;
  assign o_cmd_fire  = issue & tgt_ready;
  assign o_cmd_tgt   = tgt; // Controller decides if it may issue
endmodule

/* source/biu_ctrl.sv */
/*
  Tracks outstanding BIU transactions in a small target queue.
  A new command may only follow commands to the same target, which keeps
  responses in order without reordering logic. Depth must be 2 or more.
*/
`timescale 1ns/1ns
`include "biu_params.svh"

module biu_ctrl (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_cmd_fire,
  input  biu_route_pkg::biu_tgt_e i_cmd_tgt,
  input  logic                    i_rsp_fire,
  input  logic                    i_cmd_valid,
  output logic                    o_cmd_allow,
  output logic                    o_head_valid,
  output biu_route_pkg::biu_tgt_e o_head_tgt,
  output logic                    o_biu_active
);

  localparam int PTR_W = $clog2(`BIU_OUTS_DEPTH);

  biu_route_pkg::biu_tgt_e   tgt_q [`BIU_OUTS_DEPTH];
  logic [PTR_W-1:0]          wr_ptr;
  logic [PTR_W-1:0]          rd_ptr;
  biu_route_pkg::outs_cnt_t  outs_cnt;
  biu_route_pkg::biu_tgt_e   last_tgt; // Target of youngest command in flight
  logic                      empty;
  logic                      has_room;

  // Wrapping increment, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(`BIU_OUTS_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Target queue
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      outs_cnt <= '0;
      last_tgt <= biu_route_pkg::TGT_ERR;
      for (int i = 0; i < `BIU_OUTS_DEPTH; i++) begin
        tgt_q[i] <= biu_route_pkg::TGT_ERR;
      end
    end else begin
      if (i_cmd_fire) begin
        tgt_q[wr_ptr] <= i_cmd_tgt;
        wr_ptr        <= ptr_inc(wr_ptr);
        last_tgt      <= i_cmd_tgt;
      end
      if (i_rsp_fire) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({i_cmd_fire, i_rsp_fire})
        2'b10:   outs_cnt <= outs_cnt + 1'b1;
        2'b01:   outs_cnt <= outs_cnt - 1'b1;
        default: outs_cnt <= outs_cnt; // Idle or push with pop
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Issue rule
  assign empty    = (outs_cnt == '0);
  assign has_room = (outs_cnt < biu_route_pkg::outs_cnt_t'(`BIU_OUTS_DEPTH));

  // Same target as the youngest outstanding command, or nothing in flight
  assign o_cmd_allow = has_room & (empty | (i_cmd_tgt == last_tgt));

  assign o_head_valid = ~empty;
  assign o_head_tgt   = tgt_q[rd_ptr]; // Oldest command, owns the response path

  // Busy while anything is in flight or waiting to issue
  assign o_biu_active = ~empty | i_cmd_valid;

endmodule

/* source/biu_icb_pkg.sv */
/*
  ICB command and response field types.
  Lock, exclusive and burst fields are not carried.
*/
`include "biu_params.svh"

package biu_icb_pkg;

  typedef logic [`BIU_ADDR_W-1:0] icb_addr_t;
  typedef logic [`BIU_DATA_W-1:0] icb_data_t;
  typedef logic [`BIU_MASK_W-1:0] icb_mask_t;
  typedef logic [1:0]             icb_size_t; // 0 byte, 1 half, 2 word

  ////////////////////////////////////////////////////////////////////////////
  // Command channel payload
  typedef struct packed {
    icb_addr_t addr;
    logic      read;  // High for a read, low for a write
    icb_data_t wdata;
    icb_mask_t wmask; // Byte enables of wdata
    icb_size_t size;
  } icb_cmd_t;

  ////////////////////////////////////////////////////////////////////////////
  // Response channel payload
  typedef struct packed {
    logic      err;
    icb_data_t rdata; // Zero on writes and errors
  } icb_rsp_t;

endpackage

/* source/biu_params.svh */
/*
  Bus widths, region codes and outstanding depth for the BIU.
  The region code is taken from address bits BIU_REGION_HI..BIU_REGION_LO.
  BIU_OUTS_W must be wide enough to hold BIU_OUTS_DEPTH itself.
*/
`ifndef BIU_PARAMS_SVH
`define BIU_PARAMS_SVH

// ICB bus widths
`define BIU_ADDR_W 32
`define BIU_DATA_W 32
`define BIU_MASK_W (`BIU_DATA_W / 8)

// Region select field
`define BIU_REGION_HI 31
`define BIU_REGION_LO 28

`define BIU_PPI_REGION   1  // Private peripheral port
`define BIU_CLINT_REGION 2
`define BIU_PLIC_REGION  12 // Everything else goes to mem

// Outstanding transactions
`define BIU_OUTS_DEPTH 4
`define BIU_OUTS_W     3

`endif

/* source/biu_route_pkg.sv */
/*
  Routing types shared by the BIU controller and datapath.
  TGT_ERR marks a command answered locally with an error response.
*/
`include "biu_params.svh"

package biu_route_pkg;

  // Destination of one command
  typedef enum logic [2:0] {
    TGT_PPI,
    TGT_CLINT,
    TGT_PLIC,
    TGT_MEM,
    TGT_ERR   // Disabled region, no target sees it
  } biu_tgt_e;

  // Number of transactions in flight
  typedef logic [`BIU_OUTS_W-1:0] outs_cnt_t;

endpackage

/* source/biu_rsp_merge.sv */
/*
  Returns the response of the oldest outstanding command to the requester.
  Only the head target gets ready, so other targets wait their turn.
  An error head answers at once with err set and zero data.
*/
`timescale 1ns/1ns

module biu_rsp_merge (
  input  logic                     i_head_valid,
  input  biu_route_pkg::biu_tgt_e  i_head_tgt,
  input  logic                     i_ppi_rsp_valid,
  output logic                     o_ppi_rsp_ready,
  input  biu_icb_pkg::icb_rsp_t    i_ppi_rsp,
  input  logic                     i_clint_rsp_valid,
  output logic                     o_clint_rsp_ready,
  input  biu_icb_pkg::icb_rsp_t    i_clint_rsp,
  input  logic                     i_plic_rsp_valid,
  output logic                     o_plic_rsp_ready,
  input  biu_icb_pkg::icb_rsp_t    i_plic_rsp,
  input  logic                     i_mem_rsp_valid,
  output logic                     o_mem_rsp_ready,
  input  biu_icb_pkg::icb_rsp_t    i_mem_rsp,
  output logic                     o_rsp_valid,
  input  logic                     i_rsp_ready,
  output biu_icb_pkg::icb_rsp_t    o_rsp,
  output logic                     o_rsp_fire
);

  logic                  sel_valid;
  biu_icb_pkg::icb_rsp_t sel_rsp;

  // Head target mux
  always_comb begin
    case (i_head_tgt)
      biu_route_pkg::TGT_PPI: begin
        sel_valid = i_ppi_rsp_valid;
        sel_rsp   = i_ppi_rsp;
      end
      biu_route_pkg::TGT_CLINT: begin
        sel_valid = i_clint_rsp_valid;
        sel_rsp   = i_clint_rsp;
      end
      biu_route_pkg::TGT_PLIC: begin
        sel_valid = i_plic_rsp_valid;
        sel_rsp   = i_plic_rsp;
      end
      biu_route_pkg::TGT_MEM: begin
        sel_valid = i_mem_rsp_valid;
        sel_rsp   = i_mem_rsp;
      end
      default: begin
        sel_valid     = 1'b1; // Error reply is always ready to go
        sel_rsp.err   = 1'b1;
        sel_rsp.rdata = '0;
      end
    endcase
  end

  assign o_rsp_valid = i_head_valid & sel_valid;
  assign o_rsp       = sel_rsp;
  assign o_rsp_fire  = o_rsp_valid & i_rsp_ready;

  // Requester ready steered to the head target only
  assign o_ppi_rsp_ready   = i_rsp_ready & i_head_valid & (i_head_tgt == biu_route_pkg::TGT_PPI);
  assign o_clint_rsp_ready = i_rsp_ready & i_head_valid & (i_head_tgt == biu_route_pkg::TGT_CLINT);
  assign o_plic_rsp_ready  = i_rsp_ready & i_head_valid & (i_head_tgt == biu_route_pkg::TGT_PLIC);
  assign o_mem_rsp_ready   = i_rsp_ready & i_head_valid & (i_head_tgt == biu_route_pkg::TGT_MEM);

endmodule

/* source/biu_top.sv */
/*
  BIU top: one ICB requester routed to the ppi, clint, plic and mem targets.
  Responses come back in command order. Single clock, synchronous reset.
*/
`timescale 1ns/1ns

module biu_top (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  // Requester side
  input  logic                  i_cmd_valid,
  output logic                  o_cmd_ready,
  input  biu_icb_pkg::icb_cmd_t i_cmd,
  output logic                  o_rsp_valid,
  input  logic                  i_rsp_ready,
  output biu_icb_pkg::icb_rsp_t o_rsp,
  // Private peripheral port
  input  logic                  i_ppi_enable,
  output logic                  o_ppi_cmd_valid,
  input  logic                  i_ppi_cmd_ready,
  output biu_icb_pkg::icb_cmd_t o_ppi_cmd,
  input  logic                  i_ppi_rsp_valid,
  output logic                  o_ppi_rsp_ready,
  input  biu_icb_pkg::icb_rsp_t i_ppi_rsp,
  // CLINT
  input  logic                  i_clint_enable,
  output logic                  o_clint_cmd_valid,
  input  logic                  i_clint_cmd_ready,
  output biu_icb_pkg::icb_cmd_t o_clint_cmd,
  input  logic                  i_clint_rsp_valid,
  output logic                  o_clint_rsp_ready,
  input  biu_icb_pkg::icb_rsp_t i_clint_rsp,
  // PLIC
  input  logic                  i_plic_enable,
  output logic                  o_plic_cmd_valid,
  input  logic                  i_plic_cmd_ready,
  output biu_icb_pkg::icb_cmd_t o_plic_cmd,
  input  logic                  i_plic_rsp_valid,
  output logic                  o_plic_rsp_ready,
  input  biu_icb_pkg::icb_rsp_t i_plic_rsp,
  // System memory port
  input  logic                  i_mem_enable,
  output logic                  o_mem_cmd_valid,
  input  logic                  i_mem_cmd_ready,
  output biu_icb_pkg::icb_cmd_t o_mem_cmd,
  input  logic                  i_mem_rsp_valid,
  output logic                  o_mem_rsp_ready,
  input  biu_icb_pkg::icb_rsp_t i_mem_rsp,
  output logic                  o_biu_active
);

  logic                    cmd_allow;
  logic                    cmd_fire;
  biu_route_pkg::biu_tgt_e cmd_tgt;
  logic                    rsp_fire;
  logic                    head_valid;
  biu_route_pkg::biu_tgt_e head_tgt;

  ////////////////////////////////////////////////////////////////////////////
  // Same-named ports connect to the top ports
  biu_ctrl biu_ctrl_inst (
    .i_cmd_fire   (cmd_fire),
    .i_cmd_tgt    (cmd_tgt),
    .i_rsp_fire   (rsp_fire),
    .o_cmd_allow  (cmd_allow),
    .o_head_valid (head_valid),
    .o_head_tgt   (head_tgt),
    .*
  );

  biu_cmd_dispatch biu_cmd_dispatch_inst (
    .i_cmd_allow (cmd_allow),
    .o_cmd_fire  (cmd_fire),
    .o_cmd_tgt   (cmd_tgt),
    .*
  );

  biu_rsp_merge biu_rsp_merge_inst (
    .i_head_valid (head_valid),
    .i_head_tgt   (head_tgt),
    .o_rsp_fire   (rsp_fire),
    .*
  );

endmodule

/* verification/biu_checker.sv */
/*
  Reference model and scoreboard for biu_top, sampled on the rising edge.
  Target index 0..3 is ppi, clint, plic, mem; index 4 is a local error.
  Target read data is expected as address XOR that target's key.
*/
`timescale 1ns/1ns
`include "biu_params.svh"

module biu_checker #(
  parameter logic [3:0][31:0] TGT_KEYS = '0
) (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_cmd_valid,
  input  logic                  i_cmd_ready,
  input  biu_icb_pkg::icb_cmd_t i_cmd,
  input  logic                  i_rsp_valid,
  input  logic                  i_rsp_ready,
  input  biu_icb_pkg::icb_rsp_t i_rsp,
  input  logic [3:0]            i_enable,
  input  logic [3:0]            i_tcmd_valid,
  input  logic [3:0]            i_tcmd_ready,
  input  biu_icb_pkg::icb_cmd_t i_tcmd [4],
  input  logic [3:0]            i_trsp_valid,
  input  logic [3:0]            i_trsp_ready,
  input  logic                  i_biu_active,
  input  int                    i_test_id,
  input  logic                  i_test_done,
  input  logic                  i_run_done,
  input  int                    i_assert_fails,
  output int                    o_fail_total
);

  localparam int ERR_TGT = 4;

  biu_icb_pkg::icb_rsp_t exp_q [$]; // Expected responses in command order
  int                    tgt_q [$]; // Targets of outstanding commands, oldest first
  int                    outs_cnt = 0;
  int                    last_tgt = ERR_TGT;
  logic                  held_valid = 1'b0;
  biu_icb_pkg::icb_rsp_t held_rsp;
  logic                  rst_seen = 1'b0;
  int                    test_cmds = 0;
  int                    test_errs = 0;
  int                    total_cmds = 0;
  int                    total_errs = 0;
  int                    tests_run = 0;

  assign o_fail_total = total_errs + test_errs + i_assert_fails;

  function automatic int expect_target(input biu_icb_pkg::icb_addr_t addr,
                                       input logic [3:0] en);
    int region;
    region = int'(addr[`BIU_REGION_HI:`BIU_REGION_LO]);
    if (region == `BIU_PPI_REGION) begin
      return en[0] ? 0 : ERR_TGT;
    end
    if (region == `BIU_CLINT_REGION) begin
      return en[1] ? 1 : ERR_TGT;
    end
    if (region == `BIU_PLIC_REGION) begin
      return en[2] ? 2 : ERR_TGT;
    end
    return en[3] ? 3 : ERR_TGT; // Default region is mem
  endfunction

  function automatic string tgt_port(input int t);
    case (t)
      0:       return "o_ppi_cmd";
      1:       return "o_clint_cmd";
      2:       return "o_plic_cmd";
      default: return "o_mem_cmd";
    endcase
  endfunction

  task automatic report_mismatch(input string sig, input logic [71:0] exp_val,
                                 input logic [71:0] act_val);
    $display("ERR %0t ns %s expected %0h actual %0h", $time, sig, exp_val, act_val);
    test_errs++;
  endtask

  task automatic report_fault(input string msg);
    $display("Check at %0t ns: %s", $time, msg);
    test_errs++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Per-cycle comparison
  always @(posedge i_clk) begin
    int                    tgt;
    logic                  allow;
    logic                  tgt_rdy;
    logic                  exp_valid;
    logic [3:0]            exp_rdy;
    biu_icb_pkg::icb_rsp_t exp_rsp;
    if (!i_rst_n) begin
      if (rst_seen) begin // Registers cleared by the previous edge
        if (i_tcmd_valid !== 4'b0) report_mismatch("o_<tgt>_cmd_valid", 0, i_tcmd_valid);
        if (i_rsp_valid !== 1'b0) report_mismatch("o_rsp_valid", 0, i_rsp_valid);
        if (i_biu_active !== 1'b0) report_mismatch("o_biu_active", 0, i_biu_active);
      end
      rst_seen = 1'b1;
      exp_q.delete();
      tgt_q.delete();
      outs_cnt   = 0;
      last_tgt   = ERR_TGT;
      held_valid = 1'b0;
    end else begin
      // Back-pressure hold
      if (held_valid && !i_rsp_valid) begin
        report_fault("response valid dropped before it was accepted");
      end else if (held_valid && i_rsp != held_rsp) begin
        report_mismatch("o_rsp", held_rsp, i_rsp);
      end
      held_valid = i_rsp_valid & ~i_rsp_ready;
      held_rsp   = i_rsp;

      // Response path follows the oldest outstanding command
      exp_valid = 1'b0;
      exp_rdy   = 4'b0;
      if (tgt_q.size() > 0) begin
        if (tgt_q[0] == ERR_TGT) begin
          exp_valid = 1'b1; // Local error reply
        end else begin
          exp_valid         = i_trsp_valid[tgt_q[0]];
          exp_rdy[tgt_q[0]] = i_rsp_ready;
        end
      end
      if (i_rsp_valid !== exp_valid) begin
        report_mismatch("o_rsp_valid", exp_valid, i_rsp_valid);
      end
      if (i_trsp_ready !== exp_rdy) begin
        report_mismatch("o_<tgt>_rsp_ready", exp_rdy, i_trsp_ready);
      end

      if (i_biu_active != ((outs_cnt != 0) || i_cmd_valid)) begin
        report_mismatch("o_biu_active", !i_biu_active, i_biu_active);
      end

      // Routing and issue rule
      tgt     = expect_target(i_cmd.addr, i_enable);
      allow   = (outs_cnt < `BIU_OUTS_DEPTH) && (outs_cnt == 0 || tgt == last_tgt);
      tgt_rdy = (tgt == ERR_TGT) ? 1'b1 : i_tcmd_ready[tgt];
      for (int t = 0; t < 4; t++) begin
        if (i_tcmd_valid[t] && (!i_cmd_valid || tgt != t || !allow)) begin
          report_fault($sformatf("%s valid raised for a command not routed there",
                                 tgt_port(t)));
        end else if (i_tcmd_valid[t] && i_tcmd[t] != i_cmd) begin
          report_mismatch(tgt_port(t), i_cmd, i_tcmd[t]);
        end
      end
      if (i_cmd_valid && allow && tgt != ERR_TGT && !i_tcmd_valid[tgt]) begin
        report_fault($sformatf("%s valid missing for a routed command", tgt_port(tgt)));
      end
      if (i_cmd_valid && i_cmd_ready != (allow & tgt_rdy)) begin
        report_mismatch("o_cmd_ready", allow & tgt_rdy, i_cmd_ready);
      end

      // In-order responses
      if (i_rsp_valid && i_rsp_ready && exp_q.size() > 0) begin
        exp_rsp = exp_q.pop_front();
        void'(tgt_q.pop_front());
        if (i_rsp.err != exp_rsp.err) report_mismatch("o_rsp.err", exp_rsp.err, i_rsp.err);
        if (i_rsp.rdata != exp_rsp.rdata) begin
          report_mismatch("o_rsp.rdata", exp_rsp.rdata, i_rsp.rdata);
        end
        outs_cnt--;
      end
      if (i_cmd_valid && i_cmd_ready) begin
        exp_rsp.err = (tgt == ERR_TGT);
        if (tgt == ERR_TGT) begin
          exp_rsp.rdata = '0;
        end else begin
          exp_rsp.rdata = i_cmd.addr ^ TGT_KEYS[tgt];
        end
        exp_q.push_back(exp_rsp);
        tgt_q.push_back(tgt);
        outs_cnt++;
        last_tgt = tgt;
        test_cmds++;
      end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reporting
    if (i_test_done) begin
      $display("test %0d finished: %0d commands, %0d errors", i_test_id, test_cmds, test_errs);
      total_cmds += test_cmds;
      total_errs += test_errs;
      tests_run++;
      test_cmds = 0;
      test_errs = 0;
    end
    if (i_run_done) begin
      $display("summary: %0d tests, %0d commands, %0d errors, %0d assertion failures",
               tests_run, total_cmds, total_errs + test_errs, i_assert_fails);
    end
  end

endmodule

/* verification/biu_ctrl_props.sv */
/*
  Concurrent checks on the BIU outstanding-transaction tracker.
  Attached to every biu_ctrl instance by bind.
  fail_cnt holds the number of failed assertions.
*/
`timescale 1ns/1ns
`include "biu_params.svh"

module biu_ctrl_props (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  biu_route_pkg::outs_cnt_t  i_outs_cnt,
  input  logic                      i_rsp_fire,
  input  logic                      i_cmd_allow
);

  int fail_cnt = 0;

  count_in_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_outs_cnt <= `BIU_OUTS_DEPTH)
    else begin
      fail_cnt++;
      $error("outstanding count above the queue depth");
    end

  // A pop needs something in flight
  no_pop_when_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_rsp_fire |-> (i_outs_cnt != '0))
    else begin
      fail_cnt++;
      $error("response popped from an empty queue");
    end

  no_allow_when_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_outs_cnt == `BIU_OUTS_DEPTH) |-> !i_cmd_allow)
    else begin
      fail_cnt++;
      $error("command allowed while the queue is full");
    end

endmodule

bind biu_ctrl biu_ctrl_props biu_ctrl_props_inst (
  .i_clk       (i_clk),
  .i_rst_n     (i_rst_n),
  .i_outs_cnt  (outs_cnt),
  .i_rsp_fire  (i_rsp_fire),
  .i_cmd_allow (o_cmd_allow)
);

/* verification/tb_biu.sv */
/*
  Testbench for biu_top. Test 0 is reset, tests 1..4 are random traffic.
  Four target models answer in order after 0..3 cycles with address XOR key.
  Inputs change on the falling edge only.
*/
`timescale 1ns/1ns
`include "biu_params.svh"

module tb_biu;

  localparam int CLK_PERIOD  = 100;
  localparam int NTESTS      = 4;
  localparam int NCMD        = 40; // Commands per test
  localparam int WATCHDOG_NS = NTESTS * NCMD * 20 * CLK_PERIOD;
  localparam logic [3:0][31:0] TGT_KEYS = {32'h4D45_4D00, 32'h504C_4900,
                                           32'h434C_4E00, 32'h5050_4900};

  // Traffic mix of one test, biases in sixteenths
  typedef struct packed {
    logic       rand_en;     // Draw the four enables at test start
    logic [4:0] valid_b;
    logic [4:0] rsp_ready_b;
    logic [4:0] cmd_ready_b;
  } test_cfg_t;

  logic                   i_clk;
  logic                   i_rst_n;
  logic                   i_cmd_valid;
  logic                   o_cmd_ready;
  biu_icb_pkg::icb_cmd_t  i_cmd;
  logic                   o_rsp_valid;
  logic                   i_rsp_ready;
  biu_icb_pkg::icb_rsp_t  o_rsp;
  logic                   o_biu_active;
  logic [3:0]             enable;     // ppi, clint, plic, mem
  wire  [3:0]             tcmd_valid;
  logic [3:0]             tcmd_ready;
  biu_icb_pkg::icb_cmd_t  tcmd [4];
  logic [3:0]             trsp_valid;
  wire  [3:0]             trsp_ready;
  biu_icb_pkg::icb_rsp_t  trsp [4];
  logic [31:0]            lfsr;
  test_cfg_t              cfg;
  int                     issued;
  int                     test_id;
  logic                   test_done;
  logic                   run_done;
  logic                   cmd_fired;
  logic [3:0]             rsp_fired;
  logic [1:0]             wait_cnt [4];
  biu_icb_pkg::icb_addr_t pend_q [4][$]; // Accepted addresses per target
  int                     fail_total;

  biu_top biu_top_inst (
    .i_clk, .i_rst_n, .i_cmd_valid, .o_cmd_ready, .i_cmd,
    .o_rsp_valid, .i_rsp_ready, .o_rsp, .o_biu_active,
    .i_ppi_enable   (enable[0]),
    .o_ppi_cmd_valid(tcmd_valid[0]), .i_ppi_cmd_ready(tcmd_ready[0]), .o_ppi_cmd(tcmd[0]),
    .i_ppi_rsp_valid(trsp_valid[0]), .o_ppi_rsp_ready(trsp_ready[0]), .i_ppi_rsp(trsp[0]),
    .i_clint_enable (enable[1]),
    .o_clint_cmd_valid(tcmd_valid[1]), .i_clint_cmd_ready(tcmd_ready[1]),
    .o_clint_cmd(tcmd[1]),
    .i_clint_rsp_valid(trsp_valid[1]), .o_clint_rsp_ready(trsp_ready[1]),
    .i_clint_rsp(trsp[1]),
    .i_plic_enable  (enable[2]),
    .o_plic_cmd_valid(tcmd_valid[2]), .i_plic_cmd_ready(tcmd_ready[2]), .o_plic_cmd(tcmd[2]),
    .i_plic_rsp_valid(trsp_valid[2]), .o_plic_rsp_ready(trsp_ready[2]), .i_plic_rsp(trsp[2]),
    .i_mem_enable   (enable[3]),
    .o_mem_cmd_valid(tcmd_valid[3]), .i_mem_cmd_ready(tcmd_ready[3]), .o_mem_cmd(tcmd[3]),
    .i_mem_rsp_valid(trsp_valid[3]), .o_mem_rsp_ready(trsp_ready[3]), .i_mem_rsp(trsp[3])
  );

  biu_checker #(.TGT_KEYS(TGT_KEYS)) biu_checker_inst (
    .i_clk, .i_rst_n, .i_cmd_valid,
    .i_cmd_ready    (o_cmd_ready),
    .i_cmd,
    .i_rsp_valid    (o_rsp_valid),
    .i_rsp_ready,
    .i_rsp          (o_rsp),
    .i_enable       (enable),
    .i_tcmd_valid   (tcmd_valid),
    .i_tcmd_ready   (tcmd_ready),
    .i_tcmd         (tcmd),
    .i_trsp_valid   (trsp_valid),
    .i_trsp_ready   (trsp_ready),
    .i_biu_active   (o_biu_active),
    .i_test_id      (test_id),
    .i_test_done    (test_done),
    .i_run_done     (run_done),
    .i_assert_fails (biu_top_inst.biu_ctrl_inst.biu_ctrl_props_inst.fail_cnt),
    .o_fail_total   (fail_total)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all tests finished");
    $display("SIMULATION FAILED");
    $finish;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  task automatic roll(input logic [4:0] bias, output logic hit);
    logic [31:0] r;
    rand_bits(4, r);
    hit = ({1'b0, r[3:0]} < bias);
  endtask

  function automatic test_cfg_t cfg_for(input int id);
    case (id)
      1:       return '{1'b0, 5'd14, 5'd14, 5'd12}; // Routing, all enabled
      2:       return '{1'b1, 5'd12, 5'd12, 5'd10}; // Disabled regions
      3:       return '{1'b0, 5'd16, 5'd4, 5'd14};  // Back-pressure to the depth limit
      default: return '{1'b1, 5'd8, 5'd8, 5'd8};
    endcase
  endfunction

  // Region biased toward the three peripheral codes
  task automatic make_cmd();
    logic [31:0] r;
    logic [3:0]  region;
    rand_bits(3, r);
    case (r[2:0])
      3'd0:    region = 4'(`BIU_PPI_REGION);
      3'd1:    region = 4'(`BIU_CLINT_REGION);
      3'd2:    region = 4'(`BIU_PLIC_REGION);
      default: begin
        rand_bits(4, r);
        region = r[3:0];
      end
    endcase
    rand_bits(28, r);
    i_cmd.addr = {region, r[27:0]};
    rand_bits(1, r);
    i_cmd.read = r[0];
    rand_bits(32, r);
    i_cmd.wdata = r;
    rand_bits(4, r);
    i_cmd.wmask = r[3:0];
    rand_bits(2, r);
    i_cmd.size = r[1:0];
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Handshakes seen at the rising edge
  always @(posedge i_clk) begin
    cmd_fired <= i_cmd_valid & o_cmd_ready;
    rsp_fired <= trsp_valid & trsp_ready;
    for (int t = 0; t < 4; t++) begin
      if (tcmd_valid[t] && tcmd_ready[t]) pend_q[t].push_back(tcmd[t].addr);
    end
  end

  // One falling edge of requester and target activity
  task automatic drive_cycle();
    logic [31:0] r;
    logic        hit;
    if (cmd_fired) i_cmd_valid = 1'b0;
    if (!i_cmd_valid && issued < NCMD) begin
      roll(cfg.valid_b, hit);
      if (hit) begin
        make_cmd();
        i_cmd_valid = 1'b1;
        issued++;
      end
    end
    roll(cfg.rsp_ready_b, hit);
    i_rsp_ready = hit;
    for (int t = 0; t < 4; t++) begin
      roll(cfg.cmd_ready_b, hit);
      tcmd_ready[t] = hit;
      if (rsp_fired[t]) begin
        void'(pend_q[t].pop_front());
        trsp_valid[t] = 1'b0;
        rand_bits(2, r);
        wait_cnt[t] = r[1:0]; // Latency of the next reply
      end
      if (!trsp_valid[t] && pend_q[t].size() > 0) begin
        if (wait_cnt[t] == 2'd0) begin
          trsp_valid[t]   = 1'b1;
          trsp[t].err     = 1'b0;
          trsp[t].rdata   = pend_q[t][0] ^ TGT_KEYS[t];
        end else begin
          wait_cnt[t]--;
        end
      end
    end
  endtask

  task automatic run_test(input int id);
    logic [31:0] r;
    logic        idle;
    cfg = cfg_for(id);
    rand_bits(4, r);
    enable  = cfg.rand_en ? r[3:0] : 4'hF;
    test_id = id;
    issued  = 0;
    do begin
      @(negedge i_clk);
      idle = (issued == NCMD) && !i_cmd_valid && !o_biu_active;
      drive_cycle();
    end while (!idle);
    test_done = 1'b1;
    @(negedge i_clk);
    test_done = 1'b0;
  endtask

  initial begin
    i_rst_n     = 1'b0;
    i_cmd_valid = 1'b0;
    i_cmd       = '0;
    i_rsp_ready = 1'b0;
    enable      = 4'h0;
    tcmd_ready  = 4'h0;
    trsp_valid  = 4'h0;
    cmd_fired   = 1'b0;
    rsp_fired   = 4'h0;
    test_done   = 1'b0;
    run_done    = 1'b0;
    test_id     = 0;
    issued      = 0;
    cfg         = '0;
    lfsr        = 32'h2016;
    for (int t = 0; t < 4; t++) begin
      trsp[t]     = '0;
      wait_cnt[t] = 2'd0;
    end

    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n   = 1'b1;
    test_done = 1'b1; // Reset state checked while reset was held
    @(negedge i_clk);
    test_done = 1'b0;

    for (int id = 1; id <= NTESTS; id++) begin
      run_test(id);
    end

    run_done = 1'b1;
    @(negedge i_clk);
    run_done = 1'b0;
    @(negedge i_clk);
    if (fail_total == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
